//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	localparam word_t RESET_PC = 32'h0000_3000;

	// Primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	// Function field of SPECIAL
	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL, ALU_LUI} alu_op_t;
	typedef enum logic [1:0] {FWD_ORIG, FWD_E, FWD_M, FWD_W} fwd_sel_t;
	typedef enum logic [2:0] {NPC_SEQ, NPC_BEQ, NPC_BNE, NPC_J, NPC_JR} npc_mode_t;
	typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_RA} wb_sel_t;
	typedef enum logic {EXT_SIGN, EXT_ZERO} ext_mode_t;

	typedef struct packed {
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic reg_we;
		alu_op_t alu_op;
		logic alu_imm;
		ext_mode_t ext_mode;
		logic mem_read;
		logic mem_write;
		wb_sel_t wb_sel;
		npc_mode_t npc_mode;
		// Where each source is first needed
		logic rs_use_d;
		logic rt_use_d;
		logic rs_use_e;
		logic rt_use_e;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		ctrl_t ctrl;
		logic valid;
		word_t op1;
		word_t op2;
		word_t imm;
	} de_reg_t;

	typedef struct packed {
		word_t pc;
		ctrl_t ctrl;
		logic valid;
		word_t alu_y;
		word_t store_data;
	} em_reg_t;

	typedef struct packed {
		word_t pc;
		ctrl_t ctrl;
		logic valid;
		word_t alu_y;
		word_t load_data;
	} mw_reg_t;

endpackage

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpu_pkg::*; (
	input wire word_t a,
	input wire word_t b,
	input wire alu_op_t op,
	input wire logic [4:0] shamt,
	output word_t y
);

	logic less;

	// Signed compare for slt
	assign less = ($signed(a) < $signed(b));

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_SLT: y = {31'd0, less};
			ALU_SLL: y = b << shamt;
			ALU_LUI: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
	input wire word_t instr,
	output ctrl_t ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		// Anything not matched below stays a no-op
		ctrl = '0;
		ctrl.rs = instr[25:21];
		ctrl.rt = instr[20:16];
		case (opcode)
			OP_SPECIAL: begin
				ctrl.rd = instr[15:11];
				ctrl.reg_we = 1'b1;
				ctrl.rs_use_e = 1'b1;
				ctrl.rt_use_e = 1'b1;
				case (funct)
					FN_ADDU: ctrl.alu_op = ALU_ADD;
					FN_SUBU: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR: ctrl.alu_op = ALU_OR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					FN_SLL: begin
						ctrl.alu_op = ALU_SLL;
						ctrl.rs_use_e = 1'b0;
					end
					FN_JR: begin
						ctrl.reg_we = 1'b0;
						ctrl.rs_use_e = 1'b0;
						ctrl.rt_use_e = 1'b0;
						ctrl.rs_use_d = 1'b1;
						ctrl.npc_mode = NPC_JR;
					end
					default: begin
						ctrl.reg_we = 1'b0;
						ctrl.rs_use_e = 1'b0;
						ctrl.rt_use_e = 1'b0;
					end
				endcase
			end
			OP_ORI, OP_LUI, OP_LW: begin
				ctrl.rd = instr[20:16];
				ctrl.reg_we = 1'b1;
				ctrl.alu_imm = 1'b1;
				ctrl.rs_use_e = (opcode != OP_LUI);
				ctrl.ext_mode = (opcode == OP_LW) ? EXT_SIGN : EXT_ZERO;
				ctrl.alu_op = (opcode == OP_ORI) ? ALU_OR :
					(opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
				ctrl.mem_read = (opcode == OP_LW);
				ctrl.wb_sel = (opcode == OP_LW) ? WB_LOAD : WB_ALU;
			end
			OP_SW: begin
				ctrl.alu_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.rs_use_e = 1'b1;
				// Store data, may still be patched in memory stage
				ctrl.rt_use_e = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				ctrl.rs_use_d = 1'b1;
				ctrl.rt_use_d = 1'b1;
				ctrl.npc_mode = (opcode == OP_BEQ) ? NPC_BEQ : NPC_BNE;
			end
			OP_J: ctrl.npc_mode = NPC_J;
			OP_JAL: begin
				ctrl.npc_mode = NPC_J;
				ctrl.rd = 5'd31;
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = WB_RA;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
	input wire ctrl_t d_ctrl,
	input wire ctrl_t e_ctrl,
	input wire ctrl_t m_ctrl,
	input wire ctrl_t w_ctrl,
	input wire logic e_valid,
	input wire logic m_valid,
	input wire logic w_valid,
	output logic stall,
	output fwd_sel_t fwd_d1,
	output fwd_sel_t fwd_d2,
	output fwd_sel_t fwd_e1,
	output fwd_sel_t fwd_e2,
	output fwd_sel_t fwd_m
);

	// Stage writes a real register that matches r
	function automatic logic hit(input ctrl_t c, input logic v, input reg_addr_t r);
		return v && c.reg_we && (c.rd != 5'd0) && (c.rd == r);
	endfunction

	// Youngest matching stage wins, even when it cannot supply yet
	function automatic fwd_sel_t pick(input logic he, input logic e_ok, input logic hm,
		input logic m_ok, input logic hw);
		if (he)
			return e_ok ? FWD_E : FWD_ORIG;
		if (hm)
			return m_ok ? FWD_M : FWD_ORIG;
		if (hw)
			return FWD_W;
		return FWD_ORIG;
	endfunction

	logic e_ready;
	logic m_ready;
	logic e_rs, e_rt, m_rs, m_rt;
	logic stall_d, stall_e;

	// Only the return address exists while in execute
	assign e_ready = (e_ctrl.wb_sel == WB_RA);
	// Load data is only usable from write-back
	assign m_ready = !m_ctrl.mem_read;

	assign e_rs = hit(e_ctrl, e_valid, d_ctrl.rs);
	assign e_rt = hit(e_ctrl, e_valid, d_ctrl.rt);
	assign m_rs = hit(m_ctrl, m_valid, d_ctrl.rs);
	assign m_rt = hit(m_ctrl, m_valid, d_ctrl.rt);

	// Branch or jr operands needed right now
	assign stall_d = (d_ctrl.rs_use_d && ((e_rs && !e_ready) || (m_rs && !m_ready))) ||
		(d_ctrl.rt_use_d && ((e_rt && !e_ready) || (m_rt && !m_ready)));

	// Load-use into the ALU; store data can wait for the memory stage
	assign stall_e = e_ctrl.mem_read &&
		((d_ctrl.rs_use_e && e_rs) || (d_ctrl.rt_use_e && !d_ctrl.mem_write && e_rt));

	assign stall = stall_d || stall_e;

	always_comb begin
		fwd_d1 = pick(e_rs, e_ready, m_rs, m_ready, hit(w_ctrl, w_valid, d_ctrl.rs));
		fwd_d2 = pick(e_rt, e_ready, m_rt, m_ready, hit(w_ctrl, w_valid, d_ctrl.rt));
		fwd_e1 = pick(1'b0, 1'b0, hit(m_ctrl, m_valid, e_ctrl.rs), m_ready,
			hit(w_ctrl, w_valid, e_ctrl.rs));
		fwd_e2 = pick(1'b0, 1'b0, hit(m_ctrl, m_valid, e_ctrl.rt), m_ready,
			hit(w_ctrl, w_valid, e_ctrl.rt));
		fwd_m = pick(1'b0, 1'b0, 1'b0, 1'b0, hit(w_ctrl, w_valid, m_ctrl.rt));
	end

endmodule

`default_nettype wire

//--- hdl/next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc import cpu_pkg::*; (
	input wire word_t pc_f,
	input wire word_t pc_d,
	input wire word_t instr_d,
	input wire word_t op1,
	input wire word_t op2,
	input wire npc_mode_t mode,
	output word_t npc
);

	word_t seq_pc;
	word_t slot_pc;
	word_t branch_pc;
	word_t jump_pc;
	logic equal;

	assign seq_pc = pc_f + 32'd4;
	// Delay slot address, base for all decode-stage targets
	assign slot_pc = pc_d + 32'd4;
	assign branch_pc = slot_pc + {{14{instr_d[15]}}, instr_d[15:0], 2'b00};
	assign jump_pc = {slot_pc[31:28], instr_d[25:0], 2'b00};
	assign equal = (op1 == op2);

	always_comb begin
		case (mode)
			NPC_BEQ: npc = equal ? branch_pc : seq_pc;
			NPC_BNE: npc = equal ? seq_pc : branch_pc;
			NPC_J: npc = jump_pc;
			NPC_JR: npc = op1;
			default: npc = seq_pc;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire reg_addr_t raddr1,
	input wire reg_addr_t raddr2,
	input wire reg_addr_t waddr,
	input wire word_t wdata,
	input wire logic we,
	output word_t rdata1,
	output word_t rdata2
);

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && (waddr != 5'd0)) begin
			regs[waddr] <= wdata;
		end
	end

	// $0 reads as zero regardless of contents
	assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; #(
	parameter word_t RESET_PC = cpu_pkg::RESET_PC
) (
	input wire logic clk,
	input wire logic reset,
	input wire word_t imem_data,
	input wire word_t dmem_rdata,
	output word_t imem_addr,
	output word_t dmem_addr,
	output word_t dmem_wdata,
	output logic dmem_we,
	output logic wb_valid,
	output word_t wb_pc,
	output reg_addr_t wb_reg,
	output word_t wb_data
);

	function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t orig,
		input word_t e_val, input word_t m_val, input word_t w_val);
		case (sel)
			FWD_E: return e_val;
			FWD_M: return m_val;
			FWD_W: return w_val;
			default: return orig;
		endcase
	endfunction

	word_t pc_f, npc;
	word_t fd_pc, fd_instr;
	logic fd_valid;
	word_t d_instr, d_imm, rf_rd1, rf_rd2, d_op1, d_op2;
	ctrl_t d_ctrl;
	de_reg_t de_r;
	em_reg_t em_r;
	mw_reg_t mw_r;
	word_t e_ra, e_a, e_rt, e_b, e_y;
	word_t m_result;
	word_t w_data;
	logic stall;
	fwd_sel_t fwd_d1, fwd_d2, fwd_e1, fwd_e2, fwd_m;

	// Fetch
	always_ff @(posedge clk) begin
		if (reset) begin
			pc_f <= RESET_PC;
			fd_valid <= 1'b0;
		end else if (!stall) begin
			pc_f <= npc;
			fd_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			fd_pc <= pc_f;
			fd_instr <= imem_data;
		end
	end

	assign imem_addr = pc_f;

	// Decode; an empty slot decodes as sll $0,$0,0
	assign d_instr = fd_valid ? fd_instr : '0;

	decoder decoder0 (
		.instr(d_instr),
		.ctrl(d_ctrl)
	);

	reg_file reg_file0 (
		.clk(clk),
		.reset(reset),
		.raddr1(d_ctrl.rs),
		.raddr2(d_ctrl.rt),
		.waddr(mw_r.ctrl.rd),
		.wdata(w_data),
		.we(wb_valid),
		.rdata1(rf_rd1),
		.rdata2(rf_rd2)
	);

	assign d_imm = (d_ctrl.ext_mode == EXT_SIGN) ?
		{{16{d_instr[15]}}, d_instr[15:0]} : {16'h0000, d_instr[15:0]};
	assign d_op1 = fwd_mux(fwd_d1, rf_rd1, e_ra, m_result, w_data);
	assign d_op2 = fwd_mux(fwd_d2, rf_rd2, e_ra, m_result, w_data);

	next_pc next_pc0 (
		.pc_f(pc_f),
		.pc_d(fd_pc),
		.instr_d(d_instr),
		.op1(d_op1),
		.op2(d_op2),
		.mode(d_ctrl.npc_mode),
		.npc(npc)
	);

	hazard_unit hazard_unit0 (
		.d_ctrl(d_ctrl),
		.e_ctrl(de_r.ctrl),
		.m_ctrl(em_r.ctrl),
		.w_ctrl(mw_r.ctrl),
		.e_valid(de_r.valid),
		.m_valid(em_r.valid),
		.w_valid(mw_r.valid),
		.stall(stall),
		.fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2),
		.fwd_e1(fwd_e1),
		.fwd_e2(fwd_e2),
		.fwd_m(fwd_m)
	);

	// Stall turns the execute slot into a bubble
	always_ff @(posedge clk) begin
		de_r.pc <= fd_pc;
		de_r.ctrl <= d_ctrl;
		de_r.op1 <= d_op1;
		de_r.op2 <= d_op2;
		de_r.imm <= d_imm;
		if (reset)
			de_r.valid <= 1'b0;
		else
			de_r.valid <= fd_valid && !stall;
	end

	// Execute
	assign e_ra = de_r.pc + 32'd8;
	assign e_a = fwd_mux(fwd_e1, de_r.op1, e_ra, m_result, w_data);
	assign e_rt = fwd_mux(fwd_e2, de_r.op2, e_ra, m_result, w_data);
	assign e_b = de_r.ctrl.alu_imm ? de_r.imm : e_rt;

	alu alu0 (
		.a(e_a),
		.b(e_b),
		.op(de_r.ctrl.alu_op),
		.shamt(de_r.imm[10:6]),
		.y(e_y)
	);

	always_ff @(posedge clk) begin
		em_r.pc <= de_r.pc;
		em_r.ctrl <= de_r.ctrl;
		em_r.alu_y <= e_y;
		em_r.store_data <= e_rt;
		if (reset)
			em_r.valid <= 1'b0;
		else
			em_r.valid <= de_r.valid;
	end

	// Memory
	assign m_result = (em_r.ctrl.wb_sel == WB_RA) ? em_r.pc + 32'd8 : em_r.alu_y;
	assign dmem_addr = em_r.alu_y;
	// Late patch for a load right before the store
	assign dmem_wdata = fwd_mux(fwd_m, em_r.store_data, e_ra, m_result, w_data);
	assign dmem_we = em_r.valid && em_r.ctrl.mem_write;

	always_ff @(posedge clk) begin
		mw_r.pc <= em_r.pc;
		mw_r.ctrl <= em_r.ctrl;
		mw_r.alu_y <= em_r.alu_y;
		mw_r.load_data <= dmem_rdata;
		if (reset)
			mw_r.valid <= 1'b0;
		else
			mw_r.valid <= em_r.valid;
	end

	// Write-back
	always_comb begin
		case (mw_r.ctrl.wb_sel)
			WB_LOAD: w_data = mw_r.load_data;
			WB_RA: w_data = mw_r.pc + 32'd8;
			default: w_data = mw_r.alu_y;
		endcase
	end

	assign wb_valid = mw_r.valid && mw_r.ctrl.reg_we && (mw_r.ctrl.rd != 5'd0);
	assign wb_pc = mw_r.pc;
	assign wb_reg = mw_r.ctrl.rd;
	assign wb_data = w_data;

endmodule

`default_nettype wire

//--- testbench/tb_golden.svh
// One expected register write, in trace order
typedef struct packed {
	word_t pc;
	reg_addr_t rd;
	word_t data;
} wb_rec_t;

typedef struct packed {
	word_t addr;
	word_t data;
} store_rec_t;

localparam int PROG_WORDS = 256;
localparam int RAND_END = 200;

word_t prog [PROG_WORDS];
int prog_len;
wb_rec_t exp_wb [$];
store_rec_t exp_st [$];

function automatic word_t r_word(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rt,
	input reg_addr_t rd, input logic [4:0] sh);
	return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t i_word(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
	input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

// Target given as a word index into the program
function automatic word_t j_word(input logic [5:0] op, input int idx);
	word_t dest;
	dest = RESET_PC + word_t'(idx * 4);
	return {op, dest[27:2]};
endfunction

function automatic void put(input word_t w);
	prog[prog_len] = w;
	prog_len++;
endfunction

// Outside the program the fetch sees nops
function automatic word_t fetch_word(input word_t addr);
	word_t off;
	off = addr - RESET_PC;
	if (off < word_t'(4 * PROG_WORDS))
		return prog[off[9:2]];
	return '0;
endfunction

function automatic word_t fill_word(input int unsigned idx);
	word_t addr;
	addr = word_t'(idx) << 2;
	return (addr * 32'h9e37_79b1) ^ 32'h6b43_a9b5;
endfunction

function automatic void build_program();
	logic [5:0] alu_fns [6];
	logic [5:0] fn;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	int kind;
	int off;
	alu_fns = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT, FN_SLL};
	prog_len = 0;
	for (int i = 0; i < PROG_WORDS; i++)
		prog[i] = '0;
	put(i_word(OP_LUI, 0, 1, 16'h1234));
	put(i_word(OP_ORI, 1, 1, 16'h5678));
	put(i_word(OP_ORI, 0, 2, 16'h00ff));
	put(r_word(FN_ADDU, 1, 2, 3, 0));
	put(r_word(FN_SUBU, 3, 1, 4, 0));
	put(r_word(FN_AND, 4, 3, 5, 0));
	put(r_word(FN_OR, 5, 2, 6, 0));
	put(r_word(FN_SLT, 4, 1, 7, 0));
	put(r_word(FN_SLL, 0, 6, 8, 4));
	put(i_word(OP_ORI, 0, 9, 16'h0040));
	put(i_word(OP_SW, 9, 1, 16'h0008));
	put(i_word(OP_LW, 9, 10, 16'h0008));
	// Load-use, then store data straight from a load
	put(r_word(FN_ADDU, 10, 10, 11, 0));
	put(i_word(OP_LW, 9, 12, 16'h000c));
	put(i_word(OP_SW, 9, 12, 16'h0010));
	put(i_word(OP_LW, 9, 13, 16'h0010));
	// Load feeding a taken beq, slot runs, index 18 skipped
	put(i_word(OP_BEQ, 13, 12, 16'd2));
	put(r_word(FN_ADDU, 13, 1, 14, 0));
	put(i_word(OP_ORI, 0, 15, 16'hdead));
	put(i_word(OP_BNE, 14, 14, 16'd1));
	put(i_word(OP_ORI, 0, 15, 16'h0001));
	put(r_word(FN_ADDU, 15, 15, 16, 0));
	// jal to 26, jr back to 24, j on to 30
	put(j_word(OP_JAL, 26));
	put(r_word(FN_ADDU, 31, 0, 17, 0));
	put(j_word(OP_J, 30));
	put(i_word(OP_ORI, 0, 21, 16'h0025));
	put(r_word(FN_ADDU, 31, 0, 19, 0));
	put(r_word(FN_JR, 31, 0, 0, 0));
	put(i_word(OP_ORI, 0, 20, 16'h0028));
	put(i_word(OP_ORI, 0, 18, 16'h0bad));
	while (prog_len < RAND_END) begin
		kind = $urandom_range(9, 0);
		rs = reg_addr_t'($urandom_range(7, 0));
		rt = reg_addr_t'($urandom_range(7, 0));
		rd = reg_addr_t'($urandom_range(7, 1));
		case (kind)
			5: put(i_word(OP_ORI, rs, rd, 16'($urandom)));
			6: put(i_word(OP_LUI, 0, rd, 16'($urandom)));
			7: put(i_word(OP_LW, 0, rd, 16'($urandom_range(255, 0) << 2)));
			8: put(i_word(OP_SW, 0, rt, 16'($urandom_range(255, 0) << 2)));
			9: begin
				// Forward branch with a plain delay slot
				if (prog_len < RAND_END - 2) begin
					off = $urandom_range(3, 1);
					fn = ($urandom_range(1, 0) == 0) ? OP_BEQ : OP_BNE;
					put(i_word(fn, rs, rt, 16'(off)));
					put(r_word(FN_OR, rt, rs, rd, 0));
				end
			end
			default: begin
				fn = alu_fns[$urandom_range(5, 0)];
				if (fn == FN_SLL)
					put(r_word(fn, 0, rt, rd, 5'($urandom)));
				else
					put(r_word(fn, rs, rt, rd, 0));
			end
		endcase
	end
	// Tail of nops covers the last branch targets
	prog_len = prog_len + 6;
endfunction

// Instruction-level model, pc/npc pair gives the delay slot
function automatic void run_golden();
	word_t r [32];
	word_t m [256];
	word_t pc;
	word_t npc;
	word_t nxt;
	word_t ins;
	word_t a;
	word_t b;
	word_t imm_s;
	word_t ea;
	word_t res;
	reg_addr_t dst;
	logic wr;
	int steps;
	for (int i = 0; i < 32; i++)
		r[i] = '0;
	for (int i = 0; i < 256; i++)
		m[i] = fill_word(i);
	pc = RESET_PC;
	npc = RESET_PC + 32'd4;
	steps = 0;
	while ((pc - RESET_PC) < word_t'(4 * prog_len) && steps < 4096) begin
		ins = fetch_word(pc);
		a = r[ins[25:21]];
		b = r[ins[20:16]];
		imm_s = {{16{ins[15]}}, ins[15:0]};
		ea = a + imm_s;
		nxt = npc + 32'd4;
		wr = 1'b1;
		dst = ins[20:16];
		res = '0;
		case (ins[31:26])
			OP_SPECIAL: begin
				dst = ins[15:11];
				case (ins[5:0])
					FN_ADDU: res = a + b;
					FN_SUBU: res = a - b;
					FN_AND: res = a & b;
					FN_OR: res = a | b;
					FN_SLT: res = {31'd0, ($signed(a) < $signed(b))};
					FN_SLL: res = b << ins[10:6];
					FN_JR: begin
						wr = 1'b0;
						nxt = a;
					end
					default: wr = 1'b0;
				endcase
			end
			OP_ORI: res = a | {16'h0000, ins[15:0]};
			OP_LUI: res = {ins[15:0], 16'h0000};
			OP_LW: res = m[ea[9:2]];
			OP_SW: begin
				wr = 1'b0;
				m[ea[9:2]] = b;
				exp_st.push_back('{ea, b});
			end
			OP_BEQ, OP_BNE: begin
				wr = 1'b0;
				if ((a == b) == (ins[31:26] == OP_BEQ))
					nxt = npc + (imm_s << 2);
			end
			OP_J, OP_JAL: begin
				nxt = {npc[31:28], ins[25:0], 2'b00};
				wr = (ins[31:26] == OP_JAL);
				dst = 5'd31;
				res = pc + 32'd8;
			end
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0) begin
			r[dst] = res;
			exp_wb.push_back('{pc, dst, res});
		end
		pc = npc;
		npc = nxt;
		steps++;
	end
endfunction

//--- testbench/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic reset;
	word_t imem_data;
	word_t dmem_rdata;
	word_t imem_addr;
	word_t dmem_addr;
	word_t dmem_wdata;
	logic dmem_we;
	logic wb_valid;
	word_t wb_pc;
	reg_addr_t wb_reg;
	word_t wb_data;

	word_t dmem [256];
	int wb_count;
	int st_count;

	`include "tb_golden.svh"

	cpu #(
		.RESET_PC(RESET_PC)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.imem_data(imem_data),
		.dmem_rdata(dmem_rdata),
		.imem_addr(imem_addr),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.wb_valid(wb_valid),
		.wb_pc(wb_pc),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input word_t expv, input word_t actv);
		fail_run($sformatf("ERR %s: expected %h, actual %h", name, expv, actv));
	endtask

	// Both memories answer just after the edge
	always @(posedge clk) begin
		#2;
		imem_data = fetch_word(imem_addr);
		dmem_rdata = dmem[dmem_addr[9:2]];
	end

	// Trace and stores against the golden queues
	always @(posedge clk) begin
		if (!reset) begin
			assert (!$isunknown({wb_valid, dmem_we}))
				else fail_run("trace valid or store enable is unknown");
		end
		if (wb_valid === 1'b1) begin
			assert (wb_count < exp_wb.size())
				else fail_run("register write beyond the expected trace");
			assert (wb_pc == exp_wb[wb_count].pc)
				else report_mismatch($sformatf("write %0d pc", wb_count),
					exp_wb[wb_count].pc, wb_pc);
			assert (wb_reg == exp_wb[wb_count].rd)
				else report_mismatch($sformatf("write %0d reg", wb_count),
					{27'd0, exp_wb[wb_count].rd}, {27'd0, wb_reg});
			assert (wb_data == exp_wb[wb_count].data)
				else report_mismatch($sformatf("write %0d data", wb_count),
					exp_wb[wb_count].data, wb_data);
			wb_count++;
		end
		if (dmem_we === 1'b1) begin
			assert (st_count < exp_st.size())
				else fail_run("store beyond the expected store list");
			assert (dmem_addr == exp_st[st_count].addr)
				else report_mismatch($sformatf("store %0d addr", st_count),
					exp_st[st_count].addr, dmem_addr);
			assert (dmem_wdata == exp_st[st_count].data)
				else report_mismatch($sformatf("store %0d data", st_count),
					exp_st[st_count].data, dmem_wdata);
			dmem[dmem_addr[9:2]] = dmem_wdata;
			st_count++;
		end
	end

	initial begin
		int cycles;
		clk = 1'b0;
		reset = 1'b1;
		imem_data = '0;
		dmem_rdata = '0;
		wb_count = 0;
		st_count = 0;
		void'($urandom(32'hb3c34f46));
		for (int i = 0; i < 256; i++)
			dmem[i] = fill_word(i);
		build_program();
		run_golden();
		$display("program %0d words, %0d writes and %0d stores expected",
			prog_len, exp_wb.size(), exp_st.size());

		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			#1;
			assert (imem_addr == RESET_PC)
				else report_mismatch("reset pc", RESET_PC, imem_addr);
			assert (dmem_we === 1'b0 && wb_valid === 1'b0)
				else fail_run("store enable or trace valid high during reset");
		end
		#1;
		reset = 1'b0;

		cycles = 0;
		while (wb_count < exp_wb.size() || st_count < exp_st.size()) begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
				fail_run("timeout waiting for the expected writes and stores");
		end

		// Only nops follow, so nothing more may show up
		repeat (16) @(posedge clk);
		#1;
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+testbench
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/decoder.sv
hdl/hazard_unit.sv
hdl/next_pc.sv
hdl/reg_file.sv
hdl/cpu.sv
testbench/tb_cpu.sv
